// File: src.f
src/gfx_geom_pkg.sv
src/pa_regs_pkg.sv
src/index_buffer.sv
src/vertex_buffer.sv
src/primitive_assembler.sv
src/pa_config_regs.sv
src/geometry_frontend_top.sv
testbench/pa_assertions.sv
testbench/pa_checker.sv
testbench/tb_geometry_frontend.sv

// File: Makefile
# Verilator build for the geometry front end testbench

VERILATOR ?= verilator
TOP       ?= tb_geometry_frontend
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/tb_geometry_frontend.sv
//################################################
// Testbench for the geometry front end
// Inputs change 2 ns after the rising edge
// Ack rises and falls after random delays
//################################################

`timescale 1ns/100ps

module tb_geometry_frontend;
    import gfx_geom_pkg::*;
    import pa_regs_pkg::*;

    localparam int     CLK_NS      = 20;
    localparam int     MAX_ACK     = 5;
    localparam int     TRI_CYCLES  = 2 * MAX_ACK + 12;    // Worst case per triangle, both phases
    localparam int     NUM_TESTS   = 6;
    localparam int     POLL_MAX    = TRI_DEPTH * TRI_CYCLES;
    localparam longint WATCHDOG_NS = NUM_TESTS * (TRI_DEPTH * TRI_CYCLES + 400) * CLK_NS;

    logic                    clk = 1'b0;
    logic                    rstn;
    logic                    idx_wr, vtx_wr, vtx_invalid, cfg_wr, rd_chk;
    logic [TRI_ADDR_W-1:0]   idx_addr;
    logic [3*VTX_ADDR_W-1:0] idx_data;
    logic [VTX_ADDR_W-1:0]   vtx_addr;
    logic [VTX_W-1:0]        vtx_data, tri_v0, tri_v1, tri_v2;
    logic [CFG_ADDR_W-1:0]   cfg_addr;
    logic [CFG_DATA_W-1:0]   cfg_wdata, cfg_rdata, rd_val;
    logic                    tri_req, tri_ack;
    logic [31:0]             rng = 32'hb4fb_b92e;
    int                      tb_errs, chk_errs, max_delay, ack_wait;

    geometry_frontend_top u_dut (
        .clk(clk), .rstn(rstn),
        .i_idx_wr(idx_wr), .i_idx_addr(idx_addr), .i_idx_data(idx_data),
        .i_vtx_wr(vtx_wr), .i_vtx_addr(vtx_addr), .i_vtx_data(vtx_data),
        .i_vtx_invalid(vtx_invalid),
        .i_cfg_wr(cfg_wr), .i_cfg_addr(cfg_addr), .i_cfg_wdata(cfg_wdata),
        .o_cfg_rdata(cfg_rdata),
        .o_tri_req(tri_req), .o_tri_v0(tri_v0), .o_tri_v1(tri_v1), .o_tri_v2(tri_v2),
        .i_tri_ack(tri_ack)
    );

    pa_checker u_chk (
        .clk(clk), .rstn(rstn),
        .i_idx_wr(idx_wr), .i_idx_addr(idx_addr), .i_idx_data(idx_data),
        .i_vtx_wr(vtx_wr), .i_vtx_addr(vtx_addr), .i_vtx_data(vtx_data),
        .i_vtx_invalid(vtx_invalid),
        .i_cfg_wr(cfg_wr), .i_cfg_addr(cfg_addr), .i_cfg_wdata(cfg_wdata),
        .i_cfg_rdata(cfg_rdata), .i_rd_chk(rd_chk),
        .i_tri_req(tri_req), .i_tri_ack(tri_ack),
        .i_tri_v0(tri_v0), .i_tri_v1(tri_v1), .i_tri_v2(tri_v2),
        .o_err_cnt(chk_errs)
    );

    always #(CLK_NS/2) clk = ~clk;

    function automatic logic [31:0] lcg_next();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    function automatic int draw_ack_delay();
        return (max_delay == 0) ? 0 : int'(lcg_next() % 32'(max_delay + 1));
    endfunction

    // Downstream sink, ack follows req in both phases
    always begin
        @(posedge clk);
        #2;
        if (tri_req != tri_ack) begin
            if (ack_wait == 0) begin
                tri_ack  = tri_req;
                ack_wait = draw_ack_delay();
            end else begin
                ack_wait--;
            end
        end
    end

    task automatic write_reg(input logic [CFG_ADDR_W-1:0] a, input int d);
        @(posedge clk);
        #2;
        cfg_wr    = 1'b1;
        cfg_addr  = a;
        cfg_wdata = CFG_DATA_W'(d);
        @(posedge clk);
        #2;
        cfg_wr = 1'b0;
    endtask

    task automatic read_reg(input logic [CFG_ADDR_W-1:0] a);
        @(posedge clk);
        #2;
        cfg_addr = a;
        rd_chk   = 1'b1;
        @(negedge clk);
        rd_val = cfg_rdata;
        @(posedge clk);
        #2;
        rd_chk = 1'b0;
    endtask

    task automatic write_vertex(input int a, input bit inv_en);
        logic [31:0] r1, r2;
        r1 = lcg_next();
        r2 = lcg_next();
        @(posedge clk);
        #2;
        vtx_wr      = 1'b1;
        vtx_addr    = VTX_ADDR_W'(a);
        vtx_data    = {r1[27:16], r1[11:0], r2[11:0]};
        vtx_invalid = inv_en && (r2[31:29] == 3'd0);    // About one in eight
        @(posedge clk);
        #2;
        vtx_wr = 1'b0;
    endtask

    task automatic load_indices();
        logic [31:0] r;
        for (int i = 0; i < TRI_DEPTH; i++) begin
            r = lcg_next();
            @(posedge clk);
            #2;
            idx_wr   = 1'b1;
            idx_addr = TRI_ADDR_W'(i);
            idx_data = r[3*VTX_ADDR_W-1:0];
            @(posedge clk);
            #2;
            idx_wr = 1'b0;
        end
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        do begin
            read_reg(REG_STATUS);
            n++;
        end while (!rd_val[STAT_DONE_BIT] && n < POLL_MAX);
        if (!rd_val[STAT_DONE_BIT]) begin
            $display("Run did not finish after %0d status polls", n);
            tb_errs++;
        end
        read_reg(REG_EMITTED);
    endtask

    task automatic run_job(input int cnt);
        write_reg(REG_TRI_COUNT, cnt);
        write_reg(REG_CTRL, 1);
        wait_done();
    endtask

    task automatic end_test(input int n, input string name);
        $display("Test %0d %s finished, errors so far %0d", n, name, tb_errs + chk_errs);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Simulation timed out after %0d ns", WATCHDOG_NS);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        rstn = 1'b0;
        {idx_wr, vtx_wr, vtx_invalid, cfg_wr, rd_chk, tri_ack} = '0;
        idx_addr = '0;
        idx_data = '0;
        vtx_addr = '0;
        vtx_data = '0;
        cfg_addr = '0;
        cfg_wdata = '0;
        tb_errs = 0;
        max_delay = 0;
        ack_wait = 0;
        repeat (5) @(posedge clk);
        #2;
        rstn = 1'b1;

        read_reg(REG_STATUS);
        read_reg(REG_EMITTED);
        read_reg(REG_TRI_COUNT);
        if (tri_req !== 1'b0) begin
            $display("ERR %0t: o_tri_req high after reset", $time);
            tb_errs++;
        end
        end_test(1, "reset values");

        for (int i = 0; i < VTX_DEPTH; i++) write_vertex(i, 1'b0);
        load_indices();
        run_job(int'(lcg_next() % 32) + 1);
        end_test(2, "all valid");

        for (int i = 0; i < VTX_DEPTH; i++) write_vertex(i, 1'b1);
        run_job(TRI_DEPTH);
        end_test(3, "random invalid");

        max_delay = MAX_ACK;
        run_job(TRI_DEPTH);
        end_test(4, "ack delays");

        write_reg(REG_TRI_COUNT, 0);
        write_reg(REG_CTRL, 1);
        read_reg(REG_STATUS);
        write_reg(REG_TRI_COUNT, 12);
        write_reg(REG_CTRL, 1);
        write_reg(REG_CTRL, 1);    // Lands while busy
        wait_done();
        end_test(5, "ignored starts");

        for (int i = 0; i < 4; i++) write_vertex(int'(lcg_next() % VTX_DEPTH), 1'b1);
        run_job(int'(lcg_next() % 32) + 1);
        end_test(6, "restart");

        $display("Tests run: %0d, errors: %0d", NUM_TESTS, tb_errs + chk_errs);
        if (tb_errs + chk_errs == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: testbench/pa_checker.sv
//################################################
// Reference model of the front end, fed by host writes
// Samples on the falling edge, inputs change after rise
// Counters are compared only while no run is active
//################################################

`timescale 1ns/100ps

module pa_checker (
    input  logic                                  clk,
    input  logic                                  rstn,
    input  logic                                  i_idx_wr,
    input  logic [gfx_geom_pkg::TRI_ADDR_W-1:0]   i_idx_addr,
    input  logic [3*gfx_geom_pkg::VTX_ADDR_W-1:0] i_idx_data,
    input  logic                                  i_vtx_wr,
    input  logic [gfx_geom_pkg::VTX_ADDR_W-1:0]   i_vtx_addr,
    input  logic [gfx_geom_pkg::VTX_W-1:0]        i_vtx_data,
    input  logic                                  i_vtx_invalid,
    input  logic                                  i_cfg_wr,
    input  logic [pa_regs_pkg::CFG_ADDR_W-1:0]    i_cfg_addr,
    input  logic [pa_regs_pkg::CFG_DATA_W-1:0]    i_cfg_wdata,
    input  logic [pa_regs_pkg::CFG_DATA_W-1:0]    i_cfg_rdata,
    input  logic                                  i_rd_chk,
    input  logic                                  i_tri_req,
    input  logic                                  i_tri_ack,
    input  logic [gfx_geom_pkg::VTX_W-1:0]        i_tri_v0,
    input  logic [gfx_geom_pkg::VTX_W-1:0]        i_tri_v1,
    input  logic [gfx_geom_pkg::VTX_W-1:0]        i_tri_v2,
    output int                                    o_err_cnt
);
    import gfx_geom_pkg::*;
    import pa_regs_pkg::*;

    logic [3*VTX_ADDR_W-1:0] idx_mem [TRI_DEPTH];
    logic [VTX_W:0]          vtx_mem [VTX_DEPTH];    // {invalid, vertex}
    logic [3*VTX_W-1:0]      exp_q [$];
    int                      count, exp_emit, exp_drop;
    bit                      busy, done, req_d, ack_d;

    task automatic build_stream();
        logic [3*VTX_ADDR_W-1:0] ix;
        logic [VTX_W:0]          a, b, c;
        exp_q.delete();
        exp_emit = 0;
        exp_drop = 0;
        for (int i = 0; i < count; i++) begin
            ix = idx_mem[i];
            a  = vtx_mem[ix[VTX_ADDR_W-1:0]];
            b  = vtx_mem[ix[2*VTX_ADDR_W-1:VTX_ADDR_W]];
            c  = vtx_mem[ix[3*VTX_ADDR_W-1:2*VTX_ADDR_W]];
            if (a[VTX_W] || b[VTX_W] || c[VTX_W]) begin
                exp_drop++;
            end else begin
                exp_q.push_back({c[VTX_W-1:0], b[VTX_W-1:0], a[VTX_W-1:0]});
                exp_emit++;
            end
        end
        busy = 1;
        done = 0;
    endtask

    task automatic check_read();
        logic [CFG_DATA_W-1:0] exp;
        bit                    skip;
        exp  = '0;
        skip = 0;
        case (i_cfg_addr)
            REG_TRI_COUNT: exp = CFG_DATA_W'(count);
            REG_STATUS: begin
                if (busy && i_cfg_rdata[STAT_DONE_BIT]) begin
                    if (exp_q.size() != 0)
                        $display("ERR %0t: run ended with %0d triangles missing",
                                 $time, exp_q.size());
                    if (exp_q.size() != 0) o_err_cnt++;
                    busy = 0;
                    done = 1;
                end
                exp[STAT_BUSY_BIT] = busy;
                exp[STAT_DONE_BIT] = done;
            end
            REG_EMITTED: begin
                exp  = {8'(exp_drop), 8'(exp_emit)};    // Dropped in the high byte
                skip = busy;
            end
            default: skip = 1;
        endcase
        if (!skip && i_cfg_rdata !== exp) begin
            $display("ERR %0t: reg %0d read %h, expected %h", $time, i_cfg_addr,
                     i_cfg_rdata, exp);
            o_err_cnt++;
        end
    endtask

    task automatic check_tri();
        logic [3*VTX_W-1:0] exp;
        if (exp_q.size() == 0) begin
            $display("ERR %0t: unexpected triangle %h %h %h", $time,
                     i_tri_v0, i_tri_v1, i_tri_v2);
            o_err_cnt++;
        end else begin
            exp = exp_q.pop_front();
            if ({i_tri_v2, i_tri_v1, i_tri_v0} !== exp) begin
                $display("ERR %0t: triangle %h, expected %h", $time,
                         {i_tri_v2, i_tri_v1, i_tri_v0}, exp);
                o_err_cnt++;
            end
        end
    endtask

    initial o_err_cnt = 0;

    always @(negedge clk) begin
        if (!rstn) begin
            count = 0;
            busy  = 0;
            done  = 0;
            req_d = 0;
            ack_d = 0;
            exp_emit = 0;
            exp_drop = 0;
            exp_q.delete();
        end else begin
            if (i_idx_wr) idx_mem[i_idx_addr] = i_idx_data;
            if (i_vtx_wr) vtx_mem[i_vtx_addr] = {i_vtx_invalid, i_vtx_data};
            if (i_cfg_wr && i_cfg_addr == REG_TRI_COUNT && !busy)
                count = (i_cfg_wdata > TRI_DEPTH) ? TRI_DEPTH : int'(i_cfg_wdata);
            if (i_cfg_wr && i_cfg_addr == REG_CTRL && i_cfg_wdata[0] && !busy && count != 0)
                build_stream();
            if (i_rd_chk) check_read();
            if (i_tri_req && !req_d && ack_d) begin
                $display("ERR %0t: req raised while ack still high", $time);
                o_err_cnt++;
            end
            if (i_tri_req && i_tri_ack) check_tri();    // Accepted at the next rise
            req_d = i_tri_req;
            ack_d = i_tri_ack;
        end
    end

endmodule

// File: testbench/pa_assertions.sv
//################################################
// Handshake and read strobe checks on the assembler
// Bound into every primitive_assembler instance
//################################################

`timescale 1ns/100ps

module pa_assertions (
    input logic                             clk,
    input logic                             rstn,
    input logic                             i_req,
    input logic                             i_ack,
    input logic [3*gfx_geom_pkg::VTX_W-1:0] i_tri,
    input logic                             i_idx_rd_en,
    input logic                             i_vtx_rd_en
);

    req_held: assert property (@(posedge clk) disable iff (!rstn)
        i_req && !i_ack |=> i_req)
        else $error("req dropped before ack");

    data_stable: assert property (@(posedge clk) disable iff (!rstn)
        i_req && !i_ack |=> $stable(i_tri))
        else $error("triangle data changed while req high");

    rd_exclusive: assert property (@(posedge clk) disable iff (!rstn)
        !(i_idx_rd_en && i_vtx_rd_en))
        else $error("index and vertex reads in the same cycle");

endmodule

bind primitive_assembler pa_assertions u_pa_assert (
    .clk(clk), .rstn(rstn), .i_req(o_tri_req), .i_ack(i_tri_ack),
    .i_tri({o_tri_v2, o_tri_v1, o_tri_v0}),
    .i_idx_rd_en(o_idx_rd_en), .i_vtx_rd_en(o_vtx_rd_en)
);

// File: src/geometry_frontend_top.sv
//################################################
// Geometry front end top level
// Host loads buffers and count, then writes start
// Triangles leave on a four-phase req/ack port
//################################################

`timescale 1ns/100ps

module geometry_frontend_top (
    input  logic                                  clk,
    input  logic                                  rstn,
    input  logic                                  i_idx_wr,
    input  logic [gfx_geom_pkg::TRI_ADDR_W-1:0]   i_idx_addr,
    input  logic [3*gfx_geom_pkg::VTX_ADDR_W-1:0] i_idx_data,
    input  logic                                  i_vtx_wr,
    input  logic [gfx_geom_pkg::VTX_ADDR_W-1:0]   i_vtx_addr,
    input  logic [gfx_geom_pkg::VTX_W-1:0]        i_vtx_data,
    input  logic                                  i_vtx_invalid,
    input  logic                                  i_cfg_wr,
    input  logic [pa_regs_pkg::CFG_ADDR_W-1:0]    i_cfg_addr,
    input  logic [pa_regs_pkg::CFG_DATA_W-1:0]    i_cfg_wdata,
    output logic [pa_regs_pkg::CFG_DATA_W-1:0]    o_cfg_rdata,
    output logic                                  o_tri_req,
    output logic [gfx_geom_pkg::VTX_W-1:0]        o_tri_v0,
    output logic [gfx_geom_pkg::VTX_W-1:0]        o_tri_v1,
    output logic [gfx_geom_pkg::VTX_W-1:0]        o_tri_v2,
    input  logic                                  i_tri_ack
);
    import gfx_geom_pkg::*;

    logic                    start_pulse;
    logic [TRI_CNT_W-1:0]    tri_count;
    logic                    finished, tri_emit, tri_drop;
    logic                    idx_rd_en, idx_last, idx_dv;
    logic [3*VTX_ADDR_W-1:0] idx_data;
    logic [VTX_ADDR_W-1:0]   vtx_addr0, vtx_addr1, vtx_addr2;
    logic                    vtx_rd_en, vtx_dv;
    logic [VTX_W-1:0]        v0, v1, v2;
    logic                    inv0, inv1, inv2;

    pa_config_regs u_regs (
        .clk(clk), .rstn(rstn),
        .i_cfg_wr(i_cfg_wr), .i_cfg_addr(i_cfg_addr),
        .i_cfg_wdata(i_cfg_wdata), .o_cfg_rdata(o_cfg_rdata),
        .i_finished(finished), .i_tri_emit(tri_emit), .i_tri_drop(tri_drop),
        .o_start(start_pulse), .o_tri_count(tri_count)
    );

    index_buffer u_idx_buf (
        .clk(clk), .rstn(rstn),
        .i_wr(i_idx_wr), .i_wr_addr(i_idx_addr), .i_wr_data(i_idx_data),
        .i_start(start_pulse), .i_tri_count(tri_count), .i_rd_en(idx_rd_en),
        .o_idx_data(idx_data), .o_idx_last(idx_last), .o_idx_dv(idx_dv)
    );

    vertex_buffer u_vtx_buf (
        .clk(clk),
        .i_wr(i_vtx_wr), .i_wr_addr(i_vtx_addr), .i_wr_data(i_vtx_data),
        .i_wr_invalid(i_vtx_invalid), .i_rd_en(vtx_rd_en),
        .i_rd_addr0(vtx_addr0), .i_rd_addr1(vtx_addr1), .i_rd_addr2(vtx_addr2),
        .o_v0(v0), .o_v1(v1), .o_v2(v2),
        .o_inv0(inv0), .o_inv1(inv1), .o_inv2(inv2), .o_dv(vtx_dv)
    );

    primitive_assembler u_pa (
        .clk(clk), .rstn(rstn), .i_start(start_pulse),
        .o_idx_rd_en(idx_rd_en), .i_idx_data(idx_data),
        .i_idx_last(idx_last), .i_idx_dv(idx_dv),
        .o_vtx_addr0(vtx_addr0), .o_vtx_addr1(vtx_addr1), .o_vtx_addr2(vtx_addr2),
        .o_vtx_rd_en(vtx_rd_en),
        .i_v0(v0), .i_v1(v1), .i_v2(v2),
        .i_inv0(inv0), .i_inv1(inv1), .i_inv2(inv2), .i_vtx_dv(vtx_dv),
        .o_tri_req(o_tri_req), .i_tri_ack(i_tri_ack),
        .o_tri_v0(o_tri_v0), .o_tri_v1(o_tri_v1), .o_tri_v2(o_tri_v2),
        .o_tri_emit(tri_emit), .o_tri_drop(tri_drop), .o_finished(finished)
    );

endmodule

// File: src/pa_config_regs.sv
//################################################
// Config and status registers of the assembler
// Start is ignored while busy or with count zero
// Count writes are ignored during a run
// Counts above TRI_DEPTH saturate
//################################################

`timescale 1ns/100ps

module pa_config_regs (
    input  logic                               clk,
    input  logic                               rstn,
    input  logic                               i_cfg_wr,
    input  logic [pa_regs_pkg::CFG_ADDR_W-1:0] i_cfg_addr,
    input  logic [pa_regs_pkg::CFG_DATA_W-1:0] i_cfg_wdata,
    output logic [pa_regs_pkg::CFG_DATA_W-1:0] o_cfg_rdata,
    input  logic                               i_finished,
    input  logic                               i_tri_emit,
    input  logic                               i_tri_drop,
    output logic                               o_start,
    output logic [gfx_geom_pkg::TRI_CNT_W-1:0] o_tri_count
);
    import gfx_geom_pkg::*;
    import pa_regs_pkg::*;

    logic [TRI_CNT_W-1:0]    tri_count;
    logic                    busy;
    logic                    done;
    logic [CFG_DATA_W/2-1:0] emit_cnt;
    logic [CFG_DATA_W/2-1:0] drop_cnt;
    logic                    start_ok;

    assign start_ok = i_cfg_wr && (i_cfg_addr == REG_CTRL) && i_cfg_wdata[0]
                      && !busy && (tri_count != '0);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tri_count <= '0;
            o_start   <= 1'b0;
            busy      <= 1'b0;
            done      <= 1'b0;
            emit_cnt  <= '0;
            drop_cnt  <= '0;
        end else begin
            o_start <= start_ok;
            if (i_cfg_wr && i_cfg_addr == REG_TRI_COUNT && !busy) begin
                if (i_cfg_wdata > CFG_DATA_W'(TRI_DEPTH)) tri_count <= TRI_CNT_W'(TRI_DEPTH);
                else tri_count <= i_cfg_wdata[TRI_CNT_W-1:0];
            end
            if (start_ok) begin
                busy     <= 1'b1;    // Raised with the start pulse
                done     <= 1'b0;
                emit_cnt <= '0;
                drop_cnt <= '0;
            end else begin
                if (i_finished) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
                if (i_tri_emit) emit_cnt <= emit_cnt + 1'b1;
                if (i_tri_drop) drop_cnt <= drop_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        o_cfg_rdata = '0;
        case (i_cfg_addr)
            REG_TRI_COUNT: o_cfg_rdata[TRI_CNT_W-1:0] = tri_count;
            REG_STATUS: begin
                o_cfg_rdata[STAT_BUSY_BIT] = busy;
                o_cfg_rdata[STAT_DONE_BIT] = done;
            end
            default: ;
        endcase
        if (i_cfg_addr == REG_EMITTED) o_cfg_rdata[CFG_DATA_W/2-1:0] = emit_cnt;
        if (i_cfg_addr == REG_DROPPED) o_cfg_rdata[CFG_DATA_W-1:CFG_DATA_W/2] = drop_cnt;
    end

    assign o_tri_count = tri_count;

endmodule

// File: src/primitive_assembler.sv
//################################################
// Walks the index buffer one triangle at a time
// Triangles with an invalid vertex are dropped
// Output is a four-phase req/ack handshake
// No read ahead while waiting on ack
//################################################

`timescale 1ns/100ps

module primitive_assembler (
    input  logic                                  clk,
    input  logic                                  rstn,
    input  logic                                  i_start,
    output logic                                  o_idx_rd_en,
    input  logic [3*gfx_geom_pkg::VTX_ADDR_W-1:0] i_idx_data,
    input  logic                                  i_idx_last,
    input  logic                                  i_idx_dv,
    output logic [gfx_geom_pkg::VTX_ADDR_W-1:0]   o_vtx_addr0,
    output logic [gfx_geom_pkg::VTX_ADDR_W-1:0]   o_vtx_addr1,
    output logic [gfx_geom_pkg::VTX_ADDR_W-1:0]   o_vtx_addr2,
    output logic                                  o_vtx_rd_en,
    input  logic [gfx_geom_pkg::VTX_W-1:0]        i_v0,
    input  logic [gfx_geom_pkg::VTX_W-1:0]        i_v1,
    input  logic [gfx_geom_pkg::VTX_W-1:0]        i_v2,
    input  logic                                  i_inv0,
    input  logic                                  i_inv1,
    input  logic                                  i_inv2,
    input  logic                                  i_vtx_dv,
    output logic                                  o_tri_req,
    input  logic                                  i_tri_ack,
    output logic [gfx_geom_pkg::VTX_W-1:0]        o_tri_v0,
    output logic [gfx_geom_pkg::VTX_W-1:0]        o_tri_v1,
    output logic [gfx_geom_pkg::VTX_W-1:0]        o_tri_v2,
    output logic                                  o_tri_emit,
    output logic                                  o_tri_drop,
    output logic                                  o_finished
);
    import gfx_geom_pkg::*;

    localparam logic [2:0] S_IDLE     = 3'd0;
    localparam logic [2:0] S_RD_IDX   = 3'd1;
    localparam logic [2:0] S_WAIT_IDX = 3'd2;
    localparam logic [2:0] S_RD_VTX   = 3'd3;
    localparam logic [2:0] S_WAIT_VTX = 3'd4;
    localparam logic [2:0] S_REQ      = 3'd5;
    localparam logic [2:0] S_REL      = 3'd6;
    localparam logic [2:0] S_DONE     = 3'd7;

    logic [2:0] state, state_nxt;
    logic       last_tri;
    logic       any_inv;

    assign any_inv = i_inv0 | i_inv1 | i_inv2;

    always_ff @(posedge clk) begin
        if (!rstn) state <= S_IDLE;
        else       state <= state_nxt;
    end

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE:     if (i_start) state_nxt = S_RD_IDX;
            S_RD_IDX:   state_nxt = S_WAIT_IDX;
            S_WAIT_IDX: if (i_idx_dv) state_nxt = S_RD_VTX;
            S_RD_VTX:   state_nxt = S_WAIT_VTX;
            S_WAIT_VTX: begin
                if (i_vtx_dv) begin
                    if (!any_inv)     state_nxt = S_REQ;
                    else if (last_tri) state_nxt = S_DONE;
                    else              state_nxt = S_RD_IDX;    // Drop, next triangle
                end
            end
            S_REQ:      if (i_tri_ack) state_nxt = S_REL;
            // Wait for ack low before the next triangle
            S_REL:      if (!i_tri_ack) state_nxt = last_tri ? S_DONE : S_RD_IDX;
            S_DONE:     state_nxt = S_IDLE;
            default:    state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            last_tri <= 1'b0;
        end else if (state == S_WAIT_IDX && i_idx_dv) begin
            last_tri <= i_idx_last;
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_WAIT_IDX && i_idx_dv) begin
            o_vtx_addr0 <= i_idx_data[VTX_ADDR_W-1:0];
            o_vtx_addr1 <= i_idx_data[2*VTX_ADDR_W-1:VTX_ADDR_W];
            o_vtx_addr2 <= i_idx_data[3*VTX_ADDR_W-1:2*VTX_ADDR_W];
        end
        if (state == S_WAIT_VTX && i_vtx_dv && !any_inv) begin
            o_tri_v0 <= i_v0;    // Held through req and release
            o_tri_v1 <= i_v1;
            o_tri_v2 <= i_v2;
        end
    end

    assign o_idx_rd_en = (state == S_RD_IDX);
    assign o_vtx_rd_en = (state == S_RD_VTX);
    assign o_tri_req   = (state == S_REQ);
    assign o_tri_emit  = (state == S_REQ) && i_tri_ack;
    assign o_tri_drop  = (state == S_WAIT_VTX) && i_vtx_dv && any_inv;
    assign o_finished  = (state == S_DONE);

endmodule

// File: src/vertex_buffer.sv
//################################################
// Vertex RAM with one write and three read ports
// All reads share one enable; dv follows a cycle later
// Invalid flag is stored beside each vertex
//################################################

`timescale 1ns/100ps

module vertex_buffer (
    input  logic                                clk,
    input  logic                                i_wr,
    input  logic [gfx_geom_pkg::VTX_ADDR_W-1:0] i_wr_addr,
    input  logic [gfx_geom_pkg::VTX_W-1:0]      i_wr_data,
    input  logic                                i_wr_invalid,
    input  logic                                i_rd_en,
    input  logic [gfx_geom_pkg::VTX_ADDR_W-1:0] i_rd_addr0,
    input  logic [gfx_geom_pkg::VTX_ADDR_W-1:0] i_rd_addr1,
    input  logic [gfx_geom_pkg::VTX_ADDR_W-1:0] i_rd_addr2,
    output logic [gfx_geom_pkg::VTX_W-1:0]      o_v0,
    output logic [gfx_geom_pkg::VTX_W-1:0]      o_v1,
    output logic [gfx_geom_pkg::VTX_W-1:0]      o_v2,
    output logic                                o_inv0,
    output logic                                o_inv1,
    output logic                                o_inv2,
    output logic                                o_dv
);
    import gfx_geom_pkg::*;

    // Word is {invalid, z, y, x}
    logic [VTX_W:0] mem [VTX_DEPTH];
    logic [VTX_W:0] rd0, rd1, rd2;

    always_ff @(posedge clk) begin
        if (i_wr) mem[i_wr_addr] <= {i_wr_invalid, i_wr_data};
        if (i_rd_en) begin
            rd0 <= mem[i_rd_addr0];
            rd1 <= mem[i_rd_addr1];
            rd2 <= mem[i_rd_addr2];
        end
        o_dv <= i_rd_en;
    end

    assign o_v0   = rd0[VTX_W-1:0];
    assign o_v1   = rd1[VTX_W-1:0];
    assign o_v2   = rd2[VTX_W-1:0];
    assign o_inv0 = rd0[VTX_W];
    assign o_inv1 = rd1[VTX_W];
    assign o_inv2 = rd2[VTX_W];

endmodule

// File: src/index_buffer.sv
//################################################
// Triangle index RAM, three vertex indices per word
// Index 0 sits in the low bits of a word
// Read pointer wraps at TRI_DEPTH
//################################################

`timescale 1ns/100ps

module index_buffer (
    input  logic                                  clk,
    input  logic                                  rstn,
    input  logic                                  i_wr,
    input  logic [gfx_geom_pkg::TRI_ADDR_W-1:0]   i_wr_addr,
    input  logic [3*gfx_geom_pkg::VTX_ADDR_W-1:0] i_wr_data,
    input  logic                                  i_start,
    input  logic [gfx_geom_pkg::TRI_CNT_W-1:0]    i_tri_count,
    input  logic                                  i_rd_en,
    output logic [3*gfx_geom_pkg::VTX_ADDR_W-1:0] o_idx_data,
    output logic                                  o_idx_last,
    output logic                                  o_idx_dv
);
    import gfx_geom_pkg::*;

    logic [3*VTX_ADDR_W-1:0] mem [TRI_DEPTH];
    logic [TRI_ADDR_W-1:0]   rd_ptr;

    always_ff @(posedge clk) begin
        if (i_wr) mem[i_wr_addr] <= i_wr_data;
        if (i_rd_en) o_idx_data <= mem[rd_ptr];
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rd_ptr     <= '0;
            o_idx_last <= 1'b0;
            o_idx_dv   <= 1'b0;
        end else begin
            o_idx_dv <= i_rd_en;
            if (i_start) begin
                rd_ptr <= '0;    // Rewind for a new run
            end else if (i_rd_en) begin
                rd_ptr     <= rd_ptr + 1'b1;
                o_idx_last <= ({1'b0, rd_ptr} == i_tri_count - TRI_CNT_W'(1));
            end
        end
    end

endmodule

// File: src/pa_regs_pkg.sv
//################################################
// Register map of the assembler config block
// Emitted and dropped counters share address 3
// as low and high byte
//################################################

package pa_regs_pkg;

    localparam int CFG_ADDR_W = 2;
    localparam int CFG_DATA_W = 16;

    localparam logic [CFG_ADDR_W-1:0] REG_CTRL      = 2'd0;    // Bit 0 requests a start
    localparam logic [CFG_ADDR_W-1:0] REG_TRI_COUNT = 2'd1;
    localparam logic [CFG_ADDR_W-1:0] REG_STATUS    = 2'd2;
    localparam logic [CFG_ADDR_W-1:0] REG_EMITTED   = 2'd3;    // Low half
    localparam logic [CFG_ADDR_W-1:0] REG_DROPPED   = 2'd3;    // High half

    localparam int STAT_BUSY_BIT = 0;
    localparam int STAT_DONE_BIT = 1;

endpackage

// File: src/gfx_geom_pkg.sv
//################################################
// Geometry sizes shared by the buffers and the top
// Vertex coordinates are signed, packed {z, y, x}
// with x in the low bits
//################################################

package gfx_geom_pkg;

    localparam int COORD_W    = 12;
    localparam int VTX_W      = 3 * COORD_W;    // x, y, z

    localparam int VTX_DEPTH  = 64;
    localparam int VTX_ADDR_W = $clog2(VTX_DEPTH);

    localparam int TRI_DEPTH  = 32;
    localparam int TRI_ADDR_W = $clog2(TRI_DEPTH);
    // One extra bit so a full buffer count fits
    localparam int TRI_CNT_W  = TRI_ADDR_W + 1;

endpackage
